// ==== logic/wr_rsp_bus_pkg.sv ====
`default_nettype none

// ==========================================================================
// Host channel 1 encodings and the write-response header layout
// ==========================================================================

package wr_rsp_bus_pkg;

    // Field widths of the channel 1 request and response headers
    localparam int mdata_w     = 16;
    localparam int cl_num_w    = 2;
    localparam int req_type_w  = 4;
    localparam int resp_type_w = 4;
    localparam int vector_id_w = 2;

    // Whole response header and the unused middle of an interrupt response
    localparam int c1_rsp_hdr_w = resp_type_w + 1 + cl_num_w + mdata_w;
    localparam int intr_rsvd_w  = c1_rsp_hdr_w - resp_type_w - vector_id_w;

    // Write request codes on the transmit side
    localparam logic [req_type_w-1:0] req_wrline_i = 4'h1;
    localparam logic [req_type_w-1:0] req_wrline_m = 4'h2;
    localparam logic [req_type_w-1:0] req_wrpush_i = 4'h3;

    // Response codes on the receive side
    localparam logic [resp_type_w-1:0] rsp_wrline = 4'h1;
    localparam logic [resp_type_w-1:0] rsp_intr   = 4'h8;

    // One response word, read as a write ack or as an interrupt ack
    // The type code sits in the same top bits of both views
    typedef union packed {
        struct packed {
            logic [resp_type_w-1:0] resp_type;
            // Set when one response covers every line of the packet
            logic                   format;
            // Line count minus one when packed, line index otherwise
            logic [cl_num_w-1:0]    cl_num;
            logic [mdata_w-1:0]     mdata;
        } wr;
        struct packed {
            logic [resp_type_w-1:0] resp_type;
            logic [intr_rsvd_w-1:0] rsvd;
            logic [vector_id_w-1:0] vector_id;
        } intr;
    } c1_rsp_hdr_t;

endpackage

`default_nettype wire

// ==== logic/wr_rsp_shim_pkg.sv ====
`default_nettype none

// ==========================================================================
// Sizing of the response packing shim
// ==========================================================================

package wr_rsp_shim_pkg;

    // Number of write requests that may be outstanding at once
    // The accelerator keeps the low mdata bits unique across this window
    localparam int max_active_wr_reqs = 128;

    // Low mdata bits used as the tag of a write
    localparam int tag_w = $clog2(max_active_wr_reqs);

    // Both per-tag memories hold one entry for every possible tag
    // so the tag range and the request limit must agree

endpackage

`default_nettype wire

// ==== logic/wr_pkt_len_table.sv ====
`default_nettype none

// Stores the line count of every write request under its tag and
// hands it back when a response for that tag turns up
module wr_pkt_len_table
(
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  req_valid,
    input  wire logic [wr_rsp_bus_pkg::req_type_w-1:0] req_type,
    input  wire logic [wr_rsp_bus_pkg::cl_num_w-1:0]   req_cl_len,
    input  wire logic [wr_rsp_bus_pkg::mdata_w-1:0]    req_mdata,
    input  wire logic [wr_rsp_shim_pkg::tag_w-1:0]     rsp_tag,
    output logic      [wr_rsp_bus_pkg::cl_num_w-1:0]   pkt_len
);

    // Any of the three write flavours opens a packet
    logic req_is_wr;
    assign req_is_wr = req_valid &&
                       (req_type == wr_rsp_bus_pkg::req_wrline_i ||
                        req_type == wr_rsp_bus_pkg::req_wrline_m ||
                        req_type == wr_rsp_bus_pkg::req_wrpush_i);

    // The write port is one cycle behind the request bus for timing
    logic                                req_en_q;
    logic [wr_rsp_shim_pkg::tag_w-1:0]   req_tag_q;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0] req_len_q;

    always_ff @(posedge clk)
    begin
        req_tag_q <= req_mdata[wr_rsp_shim_pkg::tag_w-1:0];
        req_len_q <= req_cl_len;
        if (reset)
            req_en_q <= 1'b0;
        else
            req_en_q <= req_is_wr;
    end

    // Encoded packet length per tag
    logic [wr_rsp_bus_pkg::cl_num_w-1:0] len_mem [wr_rsp_shim_pkg::max_active_wr_reqs];

    // A response comes at least two cycles after its request, so the
    // registered read never races the delayed write of the same tag
    always_ff @(posedge clk)
    begin
        if (req_en_q)
            len_mem[req_tag_q] <= req_len_q;
        pkt_len <= len_mem[rsp_tag];
    end

endmodule

`default_nettype wire

// ==== logic/wr_flit_counter.sv ====
`default_nettype none

// Counts the unpacked responses already seen for each tag
// Read one cycle after rsp_en, written back two cycles after it
module wr_flit_counter
(
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                rsp_en,
    input  wire logic [wr_rsp_shim_pkg::tag_w-1:0]   rsp_tag,
    input  wire logic                                pkt_eop,
    output logic                                     rdy,
    output logic      [wr_rsp_bus_pkg::cl_num_w-1:0] flit_cnt
);

    logic [wr_rsp_bus_pkg::cl_num_w-1:0] cnt_mem [wr_rsp_shim_pkg::max_active_wr_reqs];

    // ======================================================================
    // Clearing sweep after reset
    // ======================================================================

    // One entry is zeroed per cycle; rdy stays low until every tag is done
    logic [wr_rsp_shim_pkg::tag_w-1:0] clr_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            clr_idx <= '0;
            rdy     <= 1'b0;
        end
        else if (!rdy)
        begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == wr_rsp_shim_pkg::max_active_wr_reqs - 1)
                rdy <= 1'b1;
        end
    end

    // ======================================================================
    // Response pipeline and write-back
    // ======================================================================

    logic                                s1_en;
    logic                                s2_en;
    logic [wr_rsp_shim_pkg::tag_w-1:0]   s1_tag;
    logic [wr_rsp_shim_pkg::tag_w-1:0]   s2_tag;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0] s2_data;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0] ram_cnt;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0] next_cnt;
    logic                                bypass_en;

    // Single write port, owned by the sweep until it finishes
    logic                                wr_en;
    logic [wr_rsp_shim_pkg::tag_w-1:0]   wr_tag;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0] wr_data;

    assign wr_en   = !rdy || s2_en;
    assign wr_tag  = rdy ? s2_tag : clr_idx;
    assign wr_data = rdy ? s2_data : '0;

    // A read landing on the edge of the write to the same tag takes the new value
    always_ff @(posedge clk)
    begin
        if (wr_en)
            cnt_mem[wr_tag] <= wr_data;
        if (wr_en && wr_tag == rsp_tag)
            ram_cnt <= wr_data;
        else
            ram_cnt <= cnt_mem[rsp_tag];
    end

    always_ff @(posedge clk)
    begin
        s1_tag  <= rsp_tag;
        s2_tag  <= s1_tag;
        s2_data <= next_cnt;
        if (reset)
        begin
            s1_en     <= 1'b0;
            s2_en     <= 1'b0;
            bypass_en <= 1'b0;
        end
        else
        begin
            s1_en     <= rsp_en;
            s2_en     <= s1_en;
            // Back-to-back hits on one tag read memory before the write lands
            bypass_en <= rsp_en && s1_en && (s1_tag == rsp_tag);
        end
    end

    assign flit_cnt = bypass_en ? s2_data : ram_cnt;

    // The last flit restarts the count for the next packet on this tag
    assign next_cnt = pkt_eop ? '0 : flit_cnt + 1'b1;

endmodule

`default_nettype wire

// ==== logic/wr_rsp_merge.sv ====
`default_nettype none

// Response pipeline: s0 looks up the tag, s1 decides end-of-packet,
// and the output register drops or rewrites the flit
module wr_rsp_merge
(
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                in_valid,
    input  wire wr_rsp_bus_pkg::c1_rsp_hdr_t         in_hdr,
    input  wire logic [wr_rsp_bus_pkg::cl_num_w-1:0] pkt_len,
    input  wire logic [wr_rsp_bus_pkg::cl_num_w-1:0] flit_cnt,
    output logic                                     rsp_en,
    output logic      [wr_rsp_shim_pkg::tag_w-1:0]   rsp_tag,
    output logic                                     rsp_packed,
    output logic                                     pkt_eop,
    output logic                                     out_valid,
    output wr_rsp_bus_pkg::c1_rsp_hdr_t              out_hdr
);

    logic                        s0_valid;
    wr_rsp_bus_pkg::c1_rsp_hdr_t s0_hdr;
    logic                        s1_valid;
    logic                        s1_is_wr;
    logic                        s1_packed;
    wr_rsp_bus_pkg::c1_rsp_hdr_t s1_hdr;

    // ======================================================================
    // Stage s0
    // ======================================================================

    always_ff @(posedge clk)
    begin
        s0_hdr <= in_hdr;
        if (reset)
            s0_valid <= 1'b0;
        else
            s0_valid <= in_valid;
    end

    // Only write acks carry a tag; interrupts and anything else skip the lookups
    assign rsp_en     = s0_valid && (s0_hdr.wr.resp_type == wr_rsp_bus_pkg::rsp_wrline);
    assign rsp_tag    = s0_hdr.wr.mdata[wr_rsp_shim_pkg::tag_w-1:0];
    assign rsp_packed = rsp_en && s0_hdr.wr.format;

    // ======================================================================
    // Stage s1, lengths and counts are back
    // ======================================================================

    always_ff @(posedge clk)
    begin
        s1_hdr    <= s0_hdr;
        s1_packed <= rsp_packed;
        if (reset)
        begin
            s1_valid <= 1'b0;
            s1_is_wr <= 1'b0;
        end
        else
        begin
            s1_valid <= s0_valid;
            s1_is_wr <= rsp_en;
        end
    end

    // A packed ack is complete by itself
    assign pkt_eop = s1_packed || (flit_cnt == pkt_len);

    // Output register; non-final write flits vanish here
    always_ff @(posedge clk)
    begin
        out_hdr <= s1_hdr;
        if (s1_is_wr)
        begin
            out_hdr.wr.format <= 1'b1;
            out_hdr.wr.cl_num <= pkt_len;
        end
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= s1_valid && (pkt_eop || !s1_is_wr);
    end

endmodule

`default_nettype wire

// ==== logic/wr_rsp_packer.sv ====
`default_nettype none

// Write-response packing shim between the accelerator and host channel 1
// Requests pass straight through; every write gets one packed ack
module wr_rsp_packer
(
    input  wire logic                                   clk,
    input  wire logic                                   reset,
    input  wire logic                                   afu_c1_tx_valid,
    input  wire logic [wr_rsp_bus_pkg::req_type_w-1:0]  afu_c1_tx_req_type,
    input  wire logic [wr_rsp_bus_pkg::cl_num_w-1:0]    afu_c1_tx_cl_len,
    input  wire logic [wr_rsp_bus_pkg::mdata_w-1:0]     afu_c1_tx_mdata,
    input  wire logic                                   fiu_c1_tx_alm_full,
    input  wire logic                                   fiu_c1_rx_valid,
    input  wire wr_rsp_bus_pkg::c1_rsp_hdr_t            fiu_c1_rx_hdr,
    output logic                                        fiu_c1_tx_valid,
    output logic      [wr_rsp_bus_pkg::req_type_w-1:0]  fiu_c1_tx_req_type,
    output logic      [wr_rsp_bus_pkg::cl_num_w-1:0]    fiu_c1_tx_cl_len,
    output logic      [wr_rsp_bus_pkg::mdata_w-1:0]     fiu_c1_tx_mdata,
    output logic                                        afu_c1_tx_alm_full,
    output logic                                        afu_c1_rx_valid,
    output wr_rsp_bus_pkg::c1_rsp_hdr_t                 afu_c1_rx_hdr
);

    // ======================================================================
    // Request path, zero cycles
    // ======================================================================

    assign fiu_c1_tx_valid    = afu_c1_tx_valid;
    assign fiu_c1_tx_req_type = afu_c1_tx_req_type;
    assign fiu_c1_tx_cl_len   = afu_c1_tx_cl_len;
    assign fiu_c1_tx_mdata    = afu_c1_tx_mdata;

    // Hold the accelerator off while the count memory is being cleared
    logic cnt_rdy;
    assign afu_c1_tx_alm_full = fiu_c1_tx_alm_full || !cnt_rdy;

    // ======================================================================
    // Response path, three cycles
    // ======================================================================

    logic                                rsp_en;
    logic                                pkt_eop;
    logic [wr_rsp_shim_pkg::tag_w-1:0]   rsp_tag;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0] pkt_len;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0] flit_cnt;

    // The table snoops the accelerator side and filters writes itself
    wr_pkt_len_table len_table_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (afu_c1_tx_valid),
        .req_type   (afu_c1_tx_req_type),
        .req_cl_len (afu_c1_tx_cl_len),
        .req_mdata  (afu_c1_tx_mdata),
        .rsp_tag    (rsp_tag),
        .pkt_len    (pkt_len)
    );

    wr_flit_counter flit_counter_i (
        .clk      (clk),
        .reset    (reset),
        .rsp_en   (rsp_en),
        .rsp_tag  (rsp_tag),
        .pkt_eop  (pkt_eop),
        .rdy      (cnt_rdy),
        .flit_cnt (flit_cnt)
    );

    // The packed flag is already folded into pkt_eop inside the merge stage
    wr_rsp_merge merge_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (fiu_c1_rx_valid),
        .in_hdr     (fiu_c1_rx_hdr),
        .pkt_len    (pkt_len),
        .flit_cnt   (flit_cnt),
        .rsp_en     (rsp_en),
        .rsp_tag    (rsp_tag),
        .rsp_packed (),
        .pkt_eop    (pkt_eop),
        .out_valid  (afu_c1_rx_valid),
        .out_hdr    (afu_c1_rx_hdr)
    );

endmodule

`default_nettype wire

// ==== dv/wr_rsp_packer_tb.sv ====
`default_nettype none

// Directed testbench for the write-response packing shim
module wr_rsp_packer_tb;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 2;
    localparam int rsp_latency  = 3;
    localparam int num_tags     = 6;
    // The cycle budgets of the tests are summed for the watchdog with some margin
    localparam int sweep_cycles = wr_rsp_shim_pkg::max_active_wr_reqs + 8;
    localparam int test_cycles  = 20 + 30 + 30 + 30 + (num_tags * 6 + 40) + 30;
    localparam int limit_cycles = 2 * (reset_cycles + sweep_cycles + test_cycles);

    logic                                   clk;
    logic                                   reset;
    logic                                   afu_c1_tx_valid;
    logic [wr_rsp_bus_pkg::req_type_w-1:0]  afu_c1_tx_req_type;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0]    afu_c1_tx_cl_len;
    logic [wr_rsp_bus_pkg::mdata_w-1:0]     afu_c1_tx_mdata;
    logic                                   fiu_c1_tx_alm_full;
    logic                                   fiu_c1_rx_valid;
    wr_rsp_bus_pkg::c1_rsp_hdr_t            fiu_c1_rx_hdr;
    logic                                   fiu_c1_tx_valid;
    logic [wr_rsp_bus_pkg::req_type_w-1:0]  fiu_c1_tx_req_type;
    logic [wr_rsp_bus_pkg::cl_num_w-1:0]    fiu_c1_tx_cl_len;
    logic [wr_rsp_bus_pkg::mdata_w-1:0]     fiu_c1_tx_mdata;
    logic                                   afu_c1_tx_alm_full;
    logic                                   afu_c1_rx_valid;
    wr_rsp_bus_pkg::c1_rsp_hdr_t            afu_c1_rx_hdr;

    integer                                 seed;
    int                                     err_cnt;

    // Acks seen on the accelerator side together with the edge they appeared on
    wr_rsp_bus_pkg::c1_rsp_hdr_t            ack_hdr_q [$];
    time                                    ack_time_q [$];

    wr_rsp_packer dut_i (
        .clk                (clk),
        .reset              (reset),
        .afu_c1_tx_valid    (afu_c1_tx_valid),
        .afu_c1_tx_req_type (afu_c1_tx_req_type),
        .afu_c1_tx_cl_len   (afu_c1_tx_cl_len),
        .afu_c1_tx_mdata    (afu_c1_tx_mdata),
        .fiu_c1_tx_alm_full (fiu_c1_tx_alm_full),
        .fiu_c1_rx_valid    (fiu_c1_rx_valid),
        .fiu_c1_rx_hdr      (fiu_c1_rx_hdr),
        .fiu_c1_tx_valid    (fiu_c1_tx_valid),
        .fiu_c1_tx_req_type (fiu_c1_tx_req_type),
        .fiu_c1_tx_cl_len   (fiu_c1_tx_cl_len),
        .fiu_c1_tx_mdata    (fiu_c1_tx_mdata),
        .afu_c1_tx_alm_full (afu_c1_tx_alm_full),
        .afu_c1_rx_valid    (afu_c1_rx_valid),
        .afu_c1_rx_hdr      (afu_c1_rx_hdr)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(clk_period / 2) clk = ~clk;

    // Monitor of the acks that leave towards the accelerator
    always @(negedge clk)
    begin
        if (afu_c1_rx_valid === 1'b1)
        begin
            ack_hdr_q.push_back(afu_c1_rx_hdr);
            ack_time_q.push_back($time - clk_period / 2);
        end
    end

    // ==========================================================================
    // Checking helpers
    // ==========================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            err_cnt++;
            abort_run($sformatf("Mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
                                $time, what, got, exp));
        end
    endtask

    // Waits for a number of acks, then a few more cycles to catch extra ones
    task automatic collect_acks(input int count, input string what);
        int waited;
        waited = 0;
        while (ack_hdr_q.size() < count)
        begin
            if (waited > 4 * num_tags + 20)
                abort_run($sformatf("No acknowledgement arrived in time during %s", what));
            @(posedge clk);
            waited++;
        end
        repeat (rsp_latency + 2) @(posedge clk);
        check_eq(32'(ack_hdr_q.size()), 32'(count), {what, ", number of acks"});
    endtask

    // Pops one write ack and compares it with a packed ack of the given length
    task automatic check_ack(input logic [1:0] cl_num, input logic [15:0] mdata,
                             input time t_exp, input string what);
        wr_rsp_bus_pkg::c1_rsp_hdr_t h;
        time                         t;
        h = ack_hdr_q.pop_front();
        t = ack_time_q.pop_front();
        check_eq(32'(h.wr.resp_type), 32'(wr_rsp_bus_pkg::rsp_wrline), {what, ", type"});
        check_eq(32'(h.wr.format), 32'd1, {what, ", format"});
        check_eq(32'(h.wr.cl_num), 32'(cl_num), {what, ", cl_num"});
        check_eq(32'(h.wr.mdata), 32'(mdata), {what, ", mdata"});
        check_eq(32'(t), 32'(t_exp), {what, ", arrival time"});
    endtask

    // ==========================================================================
    // Bus drivers
    // ==========================================================================

    function automatic wr_rsp_bus_pkg::c1_rsp_hdr_t make_wr_hdr(input logic format,
        input logic [1:0] cl_num, input logic [15:0] mdata);
        wr_rsp_bus_pkg::c1_rsp_hdr_t h;
        h              = '0;
        h.wr.resp_type = wr_rsp_bus_pkg::rsp_wrline;
        h.wr.format    = format;
        h.wr.cl_num    = cl_num;
        h.wr.mdata     = mdata;
        return h;
    endfunction

    // One write request of a randomly chosen write flavour
    // The host side must show it in the same cycle
    task automatic send_write(input logic [15:0] mdata, input int lines);
        logic [wr_rsp_bus_pkg::req_type_w-1:0] req_type;
        int                                    pick;
        pick     = int'($unsigned($random(seed)) % 3);
        req_type = (pick == 0) ? wr_rsp_bus_pkg::req_wrline_i :
                   ((pick == 1) ? wr_rsp_bus_pkg::req_wrline_m : wr_rsp_bus_pkg::req_wrpush_i);
        @(posedge clk);
        afu_c1_tx_valid    <= 1'b1;
        afu_c1_tx_req_type <= req_type;
        afu_c1_tx_cl_len   <= 2'(lines - 1);
        afu_c1_tx_mdata    <= mdata;
        @(negedge clk);
        check_eq(32'(fiu_c1_tx_valid), 32'd1, "request valid pass-through");
        check_eq(32'(fiu_c1_tx_req_type), 32'(req_type), "request type pass-through");
        check_eq(32'(fiu_c1_tx_cl_len), 32'(lines - 1), "request length pass-through");
        check_eq(32'(fiu_c1_tx_mdata), 32'(mdata), "request mdata pass-through");
    endtask

    // Returns the edge the response was launched on
    task automatic send_rsp(input wr_rsp_bus_pkg::c1_rsp_hdr_t h, output time t);
        @(posedge clk);
        fiu_c1_rx_valid <= 1'b1;
        fiu_c1_rx_hdr   <= h;
        t = $time;
    endtask

    task automatic idle_bus();
        @(posedge clk);
        afu_c1_tx_valid <= 1'b0;
        fiu_c1_rx_valid <= 1'b0;
    endtask

    // ==========================================================================
    // Directed tests
    // ==========================================================================

    task automatic test_reset_sweep();
        int high_cycles;
        high_cycles = 0;
        @(negedge clk);
        // The accelerator is held off for one cycle per cleared count entry
        while (afu_c1_tx_alm_full !== 1'b0)
        begin
            high_cycles++;
            if (high_cycles > sweep_cycles)
                abort_run("Almost-full never dropped after the reset sweep");
            @(negedge clk);
        end
        check_eq(32'(high_cycles), 32'(wr_rsp_shim_pkg::max_active_wr_reqs),
                 "cycles of almost-full during the sweep");
        check_eq(32'(ack_hdr_q.size()), 32'd0, "acks during the sweep");
        @(posedge clk);
        fiu_c1_tx_alm_full <= 1'b1;
        @(negedge clk);
        check_eq(32'(afu_c1_tx_alm_full), 32'd1, "almost-full follows the host when set");
        @(posedge clk);
        fiu_c1_tx_alm_full <= 1'b0;
        @(negedge clk);
        check_eq(32'(afu_c1_tx_alm_full), 32'd0, "almost-full follows the host when clear");
    endtask

    task automatic test_single_line();
        time t;
        send_write(16'h1205, 1);
        idle_bus();
        send_rsp(make_wr_hdr(1'b0, 2'd0, 16'h1205), t);
        idle_bus();
        collect_acks(1, "single-line write");
        check_ack(2'd0, 16'h1205, t + rsp_latency * clk_period, "single-line ack");
    endtask

    // Four flits back to back on one tag also go through the count bypass
    // The host returns the line indices in descending order
    task automatic test_four_lines();
        time t;
        send_write(16'h340a, 4);
        idle_bus();
        for (int i = 0; i < 4; i++)
            send_rsp(make_wr_hdr(1'b0, 2'(3 - i), 16'h340a), t);
        idle_bus();
        collect_acks(1, "four-line write");
        check_ack(2'd3, 16'h340a, t + rsp_latency * clk_period, "four-line ack");
    endtask

    task automatic test_packed();
        time t;
        send_write(16'h5611, 2);
        idle_bus();
        send_rsp(make_wr_hdr(1'b1, 2'd1, 16'h5611), t);
        idle_bus();
        collect_acks(1, "packed two-line write");
        check_ack(2'd1, 16'h5611, t + rsp_latency * clk_period, "packed ack");
    endtask

    task automatic test_interleaved();
        logic [15:0]                 mdata [num_tags];
        int                          lines [num_tags];
        int                          sent [num_tags];
        time                         last_time [num_tags];
        bit                          acked [num_tags];
        int                          order [$];
        int                          pick;
        int                          tmp;
        int                          idx;
        time                         t;
        wr_rsp_bus_pkg::c1_rsp_hdr_t h;
        // Distinct tags, random upper mdata bits and lengths of 1, 2 or 4 lines
        for (int i = 0; i < num_tags; i++)
        begin
            mdata[i]      = 16'($random(seed));
            mdata[i][6:0] = 7'(32 + i);
            pick          = int'($unsigned($random(seed)) % 3);
            lines[i]      = (pick == 0) ? 1 : ((pick == 1) ? 2 : 4);
            sent[i]       = 0;
            acked[i]      = 1'b0;
            send_write(mdata[i], lines[i]);
            for (int k = 0; k < lines[i]; k++)
                order.push_back(i);
        end
        idle_bus();
        // Shuffle the flit order in place
        for (int k = order.size() - 1; k > 0; k--)
        begin
            pick     = int'($unsigned($random(seed)) % (k + 1));
            tmp      = order[k];
            order[k] = order[pick];
            order[pick] = tmp;
        end
        // Line indices of one tag come back highest first
        foreach (order[k])
        begin
            idx = order[k];
            send_rsp(make_wr_hdr(1'b0, 2'(lines[idx] - 1 - sent[idx]), mdata[idx]), t);
            last_time[idx] = t;
            sent[idx]++;
        end
        idle_bus();
        collect_acks(num_tags, "interleaved writes");
        for (int n = 0; n < num_tags; n++)
        begin
            h   = ack_hdr_q[0];
            idx = int'(h.wr.mdata[6:0]) - 32;
            if (idx < 0 || idx >= num_tags)
                abort_run("An acknowledgement came back for a tag that was never written");
            check_eq(32'(acked[idx]), 32'd0, "second ack for one interleaved tag");
            acked[idx] = 1'b1;
            check_ack(2'(lines[idx] - 1), mdata[idx],
                      last_time[idx] + rsp_latency * clk_period, "interleaved ack");
        end
    endtask

    // Interrupt acks keep every bit including the reserved field
    task automatic test_interrupt();
        wr_rsp_bus_pkg::c1_rsp_hdr_t h;
        wr_rsp_bus_pkg::c1_rsp_hdr_t got;
        time                         t;
        time                         t_got;
        h                = '0;
        h.intr.resp_type = wr_rsp_bus_pkg::rsp_intr;
        h.intr.rsvd      = 17'($random(seed));
        h.intr.vector_id = 2'($random(seed));
        send_rsp(h, t);
        idle_bus();
        collect_acks(1, "interrupt response");
        got   = ack_hdr_q.pop_front();
        t_got = ack_time_q.pop_front();
        check_eq(32'(got), 32'(h), "interrupt header");
        check_eq(32'(t_got), 32'(t + rsp_latency * clk_period), "interrupt arrival time");
    endtask

    // ==========================================================================
    // Sequence and watchdog
    // ==========================================================================

    initial
    begin
        seed               = 32'hc1b0_6f62;
        err_cnt            = 0;
        reset              = 1'b1;
        afu_c1_tx_valid    = 1'b0;
        afu_c1_tx_req_type = '0;
        afu_c1_tx_cl_len   = '0;
        afu_c1_tx_mdata    = '0;
        fiu_c1_tx_alm_full = 1'b0;
        fiu_c1_rx_valid    = 1'b0;
        fiu_c1_rx_hdr      = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        test_reset_sweep();
        test_single_line();
        test_four_lines();
        test_packed();
        test_interleaved();
        test_interrupt();
        if (err_cnt == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial
    begin
        #(limit_cycles * clk_period);
        abort_run($sformatf("Timeout, the tests did not finish within %0d cycles",
                            limit_cycles));
    end

endmodule

`default_nettype wire

// ==== wr_rsp_packer.f ====
logic/wr_rsp_bus_pkg.sv
logic/wr_rsp_shim_pkg.sv
logic/wr_pkt_len_table.sv
logic/wr_flit_counter.sv
logic/wr_rsp_merge.sv
logic/wr_rsp_packer.sv
dv/wr_rsp_packer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the packer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

top=wr_rsp_packer_tb
log=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module "$top" \
    -f wr_rsp_packer.f

./obj_dir/V"$top" | tee "$log"

if grep -q "ALL CHECKS PASSED" "$log"; then
    echo "Result: pass"
else
    echo "Result: fail"
    exit 1
fi
